/* src/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// address split
`define DCACHE_ADDR_W     32
`define DCACHE_INDEX_W    7
`define DCACHE_OFFSET_W   6
`define DCACHE_TAG_W      (`DCACHE_ADDR_W - `DCACHE_INDEX_W - `DCACHE_OFFSET_W)

// line and way geometry
`define DCACHE_LINE_BYTES 64
`define DCACHE_LINE_BITS  (`DCACHE_LINE_BYTES * 8)
`define DCACHE_WAYS       2

`endif

/* src/dcache_pkg.sv */
`default_nettype none
`include "dcache_settings.svh"

package dcache_pkg;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    // one pipeline access, held by the pipeline until accepted
    typedef struct packed {
        logic [`DCACHE_ADDR_W-1:0] addr;
        op_e                       op;
        size_e                     size;
        logic                      sign_ext;  // loads only
        logic [31:0]               wdata;     // stores only, low bits used
    } req_t;

    typedef struct packed {
        logic                     valid;
        logic [`DCACHE_TAG_W-1:0] tag;
    } tagv_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        WAIT_WRITE
    } state_e;

endpackage

`default_nettype wire

/* src/mem_bus_pkg.sv */
`default_nettype none
`include "dcache_settings.svh"

package mem_bus_pkg;

    // whole line read, address is line aligned
    typedef struct packed {
        logic [`DCACHE_ADDR_W-1:0] addr;
    } line_rd_t;

    typedef struct packed {
        logic [`DCACHE_ADDR_W-1:0]    addr;
        logic [`DCACHE_LINE_BITS-1:0] line;
    } line_wr_t;

endpackage

`default_nettype wire

/* src/dcache_ram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_ram (
    input  logic                                         clk,
    input  logic                                         rstn,
    input  logic [`DCACHE_INDEX_W-1:0]                   i_rd_index,
    input  logic [`DCACHE_INDEX_W-1:0]                   i_wr_index,
    input  logic                                         i_wr_way,
    input  logic [`DCACHE_LINE_BYTES-1:0]                i_byte_we,
    input  logic [`DCACHE_LINE_BITS-1:0]                 i_wr_line,
    input  logic                                         i_tag_we,
    input  dcache_pkg::tagv_t                            i_wr_tag,
    output logic [`DCACHE_WAYS-1:0][`DCACHE_LINE_BITS-1:0] o_rd_lines,
    output dcache_pkg::tagv_t [`DCACHE_WAYS-1:0]         o_rd_tags
);

    localparam int SETS = 1 << `DCACHE_INDEX_W;

    logic [`DCACHE_LINE_BITS-1:0] data_mem [`DCACHE_WAYS][SETS];
    logic [`DCACHE_TAG_W-1:0]     tag_mem  [`DCACHE_WAYS][SETS];
    logic [`DCACHE_WAYS-1:0][SETS-1:0] valid;  // flops so reset can clear them

    // data and tag arrays, read one cycle after the index
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (int'(i_wr_way) == w) begin
                for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
                    if (i_byte_we[b])
                        data_mem[w][i_wr_index][8*b +: 8] <= i_wr_line[8*b +: 8];
                end
                if (i_tag_we)
                    tag_mem[w][i_wr_index] <= i_wr_tag.tag;
            end
            o_rd_lines[w]      <= data_mem[w][i_rd_index];
            o_rd_tags[w].tag   <= tag_mem[w][i_rd_index];
            o_rd_tags[w].valid <= valid[w][i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (i_tag_we) begin
            valid[i_wr_way][i_wr_index] <= i_wr_tag.valid;
        end
    end

endmodule

`default_nettype wire

/* src/dcache_set_state.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_set_state (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [`DCACHE_INDEX_W-1:0] i_index,
    input  logic                       i_touch,
    input  logic                       i_touch_way,
    input  logic                       i_dirty_we,
    input  logic                       i_dirty_way,
    input  logic                       i_dirty_val,
    output logic                       o_victim_way,
    output logic                       o_victim_dirty
);

    localparam int SETS = 1 << `DCACHE_INDEX_W;

    logic [SETS-1:0]                    mru;  // most recently used way per set
    logic [`DCACHE_WAYS-1:0][SETS-1:0]  dirty;

    // two ways, so the victim is simply the other one
    assign o_victim_way   = ~mru[i_index];
    assign o_victim_dirty = dirty[o_victim_way][i_index];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mru   <= '0;
            dirty <= '0;
        end else begin
            if (i_touch)
                mru[i_index] <= i_touch_way;
            if (i_dirty_we)
                dirty[i_dirty_way][i_index] <= i_dirty_val;
        end
    end

endmodule

`default_nettype wire

/* src/dcache_writeback.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_writeback (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         i_start,
    input  logic                         i_need_write,
    input  logic [`DCACHE_LINE_BITS-1:0] i_victim_line,
    input  logic [`DCACHE_TAG_W-1:0]     i_victim_tag,
    input  logic [`DCACHE_INDEX_W-1:0]   i_index,
    input  logic                         i_clear,
    output logic                         o_done,
    output logic                         o_mem_wr_valid,
    input  logic                         i_mem_wr_ready,
    output mem_bus_pkg::line_wr_t        o_mem_wr
);

    typedef enum logic [1:0] {
        WB_INIT,
        WB_WRITE,
        WB_FINISH
    } wb_state_e;

    wb_state_e             state_q;
    mem_bus_pkg::line_wr_t wbuf;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= WB_INIT;
        end else begin
            case (state_q)
                WB_INIT:   if (i_start) state_q <= i_need_write ? WB_WRITE : WB_FINISH;
                WB_WRITE:  if (i_mem_wr_ready) state_q <= WB_FINISH;
                WB_FINISH: if (i_clear) state_q <= WB_INIT;
                default:   state_q <= WB_INIT;
            endcase
        end
    end

    // victim line leaves the array before the refill overwrites it
    always_ff @(posedge clk) begin
        if (state_q == WB_INIT && i_start) begin
            wbuf.addr <= {i_victim_tag, i_index, {`DCACHE_OFFSET_W{1'b0}}};
            wbuf.line <= i_victim_line;
        end
    end

    assign o_mem_wr       = wbuf;
    assign o_mem_wr_valid = state_q == WB_WRITE;
    assign o_done         = state_q == WB_FINISH;  // level until cleared

endmodule

`default_nettype wire

/* src/dcache_align.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_align (
    input  dcache_pkg::req_t             i_req,
    input  logic [`DCACHE_LINE_BITS-1:0] i_line,
    output logic                         o_misaligned,
    output logic [`DCACHE_LINE_BYTES-1:0] o_byte_en,
    output logic [`DCACHE_LINE_BITS-1:0] o_store_line,
    output logic [31:0]                  o_load_data
);

    logic [`DCACHE_OFFSET_W-1:0] off;
    logic [3:0]                  word_be;
    logic [31:0]                 store_word;
    logic [31:0]                 word;
    logic [31:0]                 shifted;

    assign off = i_req.addr[`DCACHE_OFFSET_W-1:0];

    always_comb begin
        case (i_req.size)
            dcache_pkg::SIZE_BYTE: begin
                word_be      = 4'b0001 << off[1:0];
                store_word   = {4{i_req.wdata[7:0]}};  // every lane, enables pick one
                o_misaligned = 1'b0;
            end
            dcache_pkg::SIZE_HALF: begin
                word_be      = 4'b0011 << off[1:0];
                store_word   = {2{i_req.wdata[15:0]}};
                o_misaligned = off[0];
            end
            default: begin
                word_be      = 4'b1111;
                store_word   = i_req.wdata;
                o_misaligned = |off[1:0];
            end
        endcase
    end

    assign o_byte_en = `DCACHE_LINE_BYTES'(word_be) << {off[5:2], 2'b00};

    // merge store data into the line under the byte enables
    always_comb begin
        for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
            o_store_line[8*b +: 8] = o_byte_en[b] ? store_word[8*(b%4) +: 8]
                                                  : i_line[8*b +: 8];
        end
    end

    assign word    = i_line[{off[5:2], 5'b00000} +: 32];
    assign shifted = word >> {off[1:0], 3'b000};

    always_comb begin
        case (i_req.size)
            dcache_pkg::SIZE_BYTE:
                o_load_data = {{24{i_req.sign_ext & shifted[7]}}, shifted[7:0]};
            dcache_pkg::SIZE_HALF:
                o_load_data = {{16{i_req.sign_ext & shifted[15]}}, shifted[15:0]};
            default:
                o_load_data = word;
        endcase
    end

endmodule

`default_nettype wire

/* src/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          i_valid,
    input  dcache_pkg::req_t              i_req,
    output logic                          o_ready,
    output logic                          o_done,
    output logic                          o_ale,
    output logic [31:0]                   o_rdata,
    output logic                          o_mem_rd_valid,
    input  logic                          i_mem_rd_ready,
    output mem_bus_pkg::line_rd_t         o_mem_rd,
    input  logic [`DCACHE_LINE_BITS-1:0]  i_mem_rd_line,
    output logic [`DCACHE_INDEX_W-1:0]    o_rd_index,
    output logic [`DCACHE_INDEX_W-1:0]    o_wr_index,
    output logic [`DCACHE_LINE_BYTES-1:0] o_byte_we,
    output logic                          o_wr_way,
    output logic [`DCACHE_LINE_BITS-1:0]  o_wr_line,
    output logic                          o_tag_we,
    output dcache_pkg::tagv_t             o_wr_tag,
    input  logic [`DCACHE_WAYS-1:0][`DCACHE_LINE_BITS-1:0] i_rd_lines,
    input  dcache_pkg::tagv_t [`DCACHE_WAYS-1:0]           i_rd_tags,
    output logic                          o_touch,
    output logic                          o_touch_way,
    output logic                          o_dirty_we,
    output logic                          o_dirty_val,
    input  logic                          i_victim_way,
    input  logic                          i_victim_dirty,
    output logic                          o_wb_start,
    input  logic                          i_wb_done,
    output logic                          o_wb_clear,
    output dcache_pkg::req_t              o_areq,
    output logic [`DCACHE_LINE_BITS-1:0]  o_src_line,
    input  logic [`DCACHE_LINE_BYTES-1:0] i_byte_en,
    input  logic [`DCACHE_LINE_BITS-1:0]  i_store_line,
    input  logic [31:0]                   i_load_data,
    input  logic                          i_misaligned
);

    dcache_pkg::state_e           state_q;
    dcache_pkg::state_e           state_d;
    dcache_pkg::req_t             req_q;
    logic [`DCACHE_LINE_BITS-1:0] ret_buf;
    logic [`DCACHE_TAG_W-1:0]     req_tag;
    logic [`DCACHE_WAYS-1:0]      hit;
    logic                         hit_way;
    logic                         is_store;
    logic                         lookup;
    logic                         lookup_done;  // hit or fault, answered this cycle
    logic                         store_hit;
    logic                         refill;
    logic                         accept;

    assign req_tag  = req_q.addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign is_store = req_q.op == dcache_pkg::OP_STORE;

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_hit
        assign hit[w] = i_rd_tags[w].valid && i_rd_tags[w].tag == req_tag;
    end
    assign hit_way = hit[1];

    assign lookup      = state_q == dcache_pkg::LOOKUP;
    assign lookup_done = lookup && (i_misaligned || |hit);
    assign store_hit   = lookup && |hit && is_store && !i_misaligned;
    assign refill      = state_q == dcache_pkg::REFILL;

    // a store hit writes the array, so no read may start beside it
    always_comb begin
        case (state_q)
            dcache_pkg::IDLE:   o_ready = 1'b1;
            dcache_pkg::LOOKUP: o_ready = i_misaligned || (|hit && !is_store);
            default:            o_ready = 1'b0;
        endcase
    end
    assign accept = i_valid && o_ready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (accept)
                    state_d = dcache_pkg::LOOKUP;
            end
            dcache_pkg::LOOKUP: begin
                if (lookup_done)
                    state_d = accept ? dcache_pkg::LOOKUP : dcache_pkg::IDLE;
                else
                    state_d = dcache_pkg::MISS;
            end
            dcache_pkg::MISS: begin
                if (i_mem_rd_ready)
                    state_d = dcache_pkg::REFILL;
            end
            dcache_pkg::REFILL: state_d = dcache_pkg::WAIT_WRITE;
            dcache_pkg::WAIT_WRITE: begin
                if (i_wb_done)
                    state_d = dcache_pkg::IDLE;
            end
            default: state_d = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= dcache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request and return buffers
    always_ff @(posedge clk) begin
        if (accept)
            req_q <= i_req;
        if (o_mem_rd_valid && i_mem_rd_ready)
            ret_buf <= i_mem_rd_line;
    end

    assign o_done = lookup_done || (state_q == dcache_pkg::WAIT_WRITE && i_wb_done);
    assign o_ale  = lookup && i_misaligned;
    assign o_rdata = i_load_data;

    assign o_mem_rd_valid = state_q == dcache_pkg::MISS;
    assign o_mem_rd.addr  = {req_q.addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W],
                             {`DCACHE_OFFSET_W{1'b0}}};

    assign o_rd_index = i_req.addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign o_wr_index = req_q.addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];

    // refill fills the victim, a store hit updates the hit way
    assign o_wr_way    = refill ? i_victim_way : hit_way;
    assign o_byte_we   = refill ? '1 : (store_hit ? i_byte_en : '0);
    assign o_wr_line   = is_store ? i_store_line : ret_buf;
    assign o_tag_we    = refill;
    assign o_wr_tag    = {1'b1, req_tag};
    assign o_touch     = refill || (lookup && |hit && !i_misaligned);
    assign o_touch_way = o_wr_way;
    assign o_dirty_we  = refill || store_hit;
    assign o_dirty_val = is_store;

    assign o_wb_start = lookup && !lookup_done;  // write-back runs beside the line read
    assign o_wb_clear = state_q == dcache_pkg::WAIT_WRITE && i_wb_done;

    assign o_areq     = req_q;
    assign o_src_line = lookup ? i_rd_lines[hit_way] : ret_buf;

endmodule

`default_nettype wire

/* src/dcache.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         i_valid,
    input  dcache_pkg::req_t             i_req,
    output logic                         o_ready,
    output logic                         o_done,
    output logic                         o_ale,
    output logic [31:0]                  o_rdata,
    output logic                         o_mem_rd_valid,
    input  logic                         i_mem_rd_ready,
    output mem_bus_pkg::line_rd_t        o_mem_rd,
    input  logic [`DCACHE_LINE_BITS-1:0] i_mem_rd_line,
    output logic                         o_mem_wr_valid,
    input  logic                         i_mem_wr_ready,
    output mem_bus_pkg::line_wr_t        o_mem_wr
);

    logic [`DCACHE_INDEX_W-1:0]    rd_index;
    logic [`DCACHE_INDEX_W-1:0]    wr_index;
    logic [`DCACHE_LINE_BYTES-1:0] byte_we;
    logic                          wr_way;
    logic [`DCACHE_LINE_BITS-1:0]  wr_line;
    logic                          tag_we;
    dcache_pkg::tagv_t             wr_tag;
    logic [`DCACHE_WAYS-1:0][`DCACHE_LINE_BITS-1:0] rd_lines;
    dcache_pkg::tagv_t [`DCACHE_WAYS-1:0]           rd_tags;
    logic                          touch;
    logic                          touch_way;
    logic                          dirty_we;
    logic                          dirty_val;
    logic                          victim_way;
    logic                          victim_dirty;
    logic                          wb_start;
    logic                          wb_done;
    logic                          wb_clear;
    dcache_pkg::req_t              areq;
    logic [`DCACHE_LINE_BITS-1:0]  src_line;
    logic [`DCACHE_LINE_BYTES-1:0] byte_en;
    logic [`DCACHE_LINE_BITS-1:0]  store_line;
    logic [31:0]                   load_data;
    logic                          misaligned;

    dcache_ctrl u_ctrl (
        .clk(clk), .rstn(rstn), .i_valid(i_valid), .i_req(i_req),
        .o_ready(o_ready), .o_done(o_done), .o_ale(o_ale), .o_rdata(o_rdata),
        .o_mem_rd_valid(o_mem_rd_valid), .i_mem_rd_ready(i_mem_rd_ready),
        .o_mem_rd(o_mem_rd), .i_mem_rd_line(i_mem_rd_line),
        .o_rd_index(rd_index), .o_wr_index(wr_index), .o_byte_we(byte_we),
        .o_wr_way(wr_way), .o_wr_line(wr_line), .o_tag_we(tag_we), .o_wr_tag(wr_tag),
        .i_rd_lines(rd_lines), .i_rd_tags(rd_tags),
        .o_touch(touch), .o_touch_way(touch_way), .o_dirty_we(dirty_we),
        .o_dirty_val(dirty_val), .i_victim_way(victim_way), .i_victim_dirty(victim_dirty),
        .o_wb_start(wb_start), .i_wb_done(wb_done), .o_wb_clear(wb_clear),
        .o_areq(areq), .o_src_line(src_line), .i_byte_en(byte_en),
        .i_store_line(store_line), .i_load_data(load_data), .i_misaligned(misaligned)
    );

    dcache_ram u_ram (
        .clk(clk), .rstn(rstn), .i_rd_index(rd_index), .i_wr_index(wr_index),
        .i_wr_way(wr_way), .i_byte_we(byte_we), .i_wr_line(wr_line),
        .i_tag_we(tag_we), .i_wr_tag(wr_tag), .o_rd_lines(rd_lines), .o_rd_tags(rd_tags)
    );

    // dirty updates always target the way being touched
    dcache_set_state u_set_state (
        .clk(clk), .rstn(rstn), .i_index(wr_index), .i_touch(touch),
        .i_touch_way(touch_way), .i_dirty_we(dirty_we), .i_dirty_way(touch_way),
        .i_dirty_val(dirty_val), .o_victim_way(victim_way), .o_victim_dirty(victim_dirty)
    );

    dcache_writeback u_writeback (
        .clk(clk), .rstn(rstn), .i_start(wb_start), .i_need_write(victim_dirty),
        .i_victim_line(rd_lines[victim_way]), .i_victim_tag(rd_tags[victim_way].tag),
        .i_index(wr_index), .i_clear(wb_clear), .o_done(wb_done),
        .o_mem_wr_valid(o_mem_wr_valid), .i_mem_wr_ready(i_mem_wr_ready), .o_mem_wr(o_mem_wr)
    );

    dcache_align u_align (
        .i_req(areq), .i_line(src_line), .o_misaligned(misaligned),
        .o_byte_en(byte_en), .o_store_line(store_line), .o_load_data(load_data)
    );

endmodule

`default_nettype wire

/* tb/dcache_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_checker (
    input wire logic                  clk,
    input wire logic                  rstn,
    input wire logic                  o_done,
    input wire logic                  o_mem_rd_valid,
    input wire logic                  i_mem_rd_ready,
    input wire mem_bus_pkg::line_rd_t o_mem_rd,
    input wire logic                  o_mem_wr_valid,
    input wire logic                  i_mem_wr_ready,
    input wire mem_bus_pkg::line_wr_t o_mem_wr
);

    // read request holds until the memory takes it
    rd_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rd_valid && !i_mem_rd_ready |=> o_mem_rd_valid && $stable(o_mem_rd))
        else $error("line read request dropped or changed before ready");

    wr_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_wr_valid && !i_mem_wr_ready |=> o_mem_wr_valid && $stable(o_mem_wr))
        else $error("line write request dropped or changed before ready");

    done_after_reset: assert property (@(posedge clk) !rstn |=> !o_done)
        else $error("done pulse right after reset");

endmodule

bind dcache dcache_checker u_checker (.*);

`default_nettype wire

/* tb/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_tb;

    localparam int NREQ = 2100;  // directed plus random requests

    typedef struct packed {
        logic        ale;
        logic        is_load;
        logic [31:0] data;
    } exp_t;

    logic                         clk = 1'b0;
    logic                         rstn = 1'b0;
    logic                         i_valid = 1'b0;
    dcache_pkg::req_t             i_req = '0;
    logic                         o_ready, o_done, o_ale;
    logic [31:0]                  o_rdata;
    logic                         o_mem_rd_valid, o_mem_wr_valid;
    logic                         i_mem_rd_ready = 1'b0;
    logic                         i_mem_wr_ready = 1'b0;
    logic [`DCACHE_LINE_BITS-1:0] i_mem_rd_line = '0;
    mem_bus_pkg::line_rd_t        o_mem_rd;
    mem_bus_pkg::line_wr_t        o_mem_wr;

    logic [7:0]                   gold [logic [31:0]];       // golden bytes
    logic [`DCACHE_LINE_BITS-1:0] mem_lines [logic [31:0]];  // backing memory
    exp_t                         exp_q [$];
    int                           errors = 0, checks = 0;
    int                           rd_cnt = 0, wr_cnt = 0, rd_wait = 0, wr_wait = 0;
    logic [31:0]                  last_rd, last_wr;

    dcache uut (.*);

    always #5 clk = ~clk;

    function automatic logic [7:0] fill_byte(logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ {a[20:16], a[23:21]} ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] gbyte(logic [31:0] a);
        return gold.exists(a) ? gold[a] : fill_byte(a);
    endfunction

    function automatic logic [`DCACHE_LINE_BITS-1:0] gold_line(logic [31:0] base);
        logic [`DCACHE_LINE_BITS-1:0] l;
        for (int b = 0; b < `DCACHE_LINE_BYTES; b++)
            l[8*b +: 8] = gbyte(base + b);
        return l;
    endfunction

    function automatic logic [`DCACHE_LINE_BITS-1:0] mem_line(logic [31:0] base);
        logic [`DCACHE_LINE_BITS-1:0] l;
        for (int b = 0; b < `DCACHE_LINE_BYTES; b++)
            l[8*b +: 8] = fill_byte(base + b);
        return mem_lines.exists(base) ? mem_lines[base] : l;
    endfunction

    // expected result from size, offset and sign rules
    function automatic exp_t ref_access(dcache_pkg::req_t r);
        exp_t        e;
        logic [31:0] w;
        w = {gbyte(r.addr + 3), gbyte(r.addr + 2), gbyte(r.addr + 1), gbyte(r.addr)};
        e.is_load = r.op == dcache_pkg::OP_LOAD;
        e.ale = (r.size == dcache_pkg::SIZE_HALF && r.addr[0])
             || (r.size == dcache_pkg::SIZE_WORD && |r.addr[1:0]);
        case (r.size)
            dcache_pkg::SIZE_BYTE: e.data = {{24{r.sign_ext & w[7]}}, w[7:0]};
            dcache_pkg::SIZE_HALF: e.data = {{16{r.sign_ext & w[15]}}, w[15:0]};
            default:               e.data = w;
        endcase
        return e;
    endfunction

    task automatic issue(input logic [31:0] addr, input dcache_pkg::op_e op,
                         input dcache_pkg::size_e size, input logic sign,
                         input logic [31:0] wdata);
        dcache_pkg::req_t r;
        exp_t             e;
        r = '{addr: addr, op: op, size: size, sign_ext: sign, wdata: wdata};
        @(negedge clk);
        i_valid = 1'b1;
        i_req   = r;
        #1;
        while (!o_ready) begin
            @(negedge clk);
            #1;
        end
        e = ref_access(r);
        exp_q.push_back(e);
        if (!e.is_load && !e.ale) begin
            for (int b = 0; b < (1 << int'(size)); b++)
                gold[addr + b] = wdata[8*b +: 8];
        end
        @(posedge clk);
    endtask

    task automatic drain();
        @(negedge clk);
        i_valid = 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk);
    endtask

    task automatic check_count(input int got, input int want, input string what);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("FAILED %0t: %s count %0d, expected %0d", $time, what, got, want);
        end
    endtask

    // compare process, one result per done pulse
    always @(negedge clk) begin
        exp_t e;
        if (rstn && o_done) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("done pulse with no request outstanding at %0t", $time);
            end else begin
                e = exp_q.pop_front();
                checks++;
                assert (o_ale == e.ale) else begin
                    errors++;
                    $display("FAILED %0t: ale %0b, expected %0b", $time, o_ale, e.ale);
                end
                if (e.is_load && !e.ale) begin
                    assert (o_rdata == e.data) else begin
                        errors++;
                        $display("FAILED %0t: rdata %h, expected %h", $time, o_rdata, e.data);
                    end
                end
            end
        end
    end

    // memory model with random delays
    always @(negedge clk) begin
        if (i_mem_rd_ready) begin
            i_mem_rd_ready <= 1'b0;
        end else if (o_mem_rd_valid) begin
            if (rd_wait == 0) begin
                i_mem_rd_ready <= 1'b1;
                i_mem_rd_line  <= mem_line(o_mem_rd.addr);
                rd_wait        <= $urandom % 4;
            end else begin
                rd_wait <= rd_wait - 1;
            end
        end
        if (i_mem_wr_ready) begin
            i_mem_wr_ready <= 1'b0;
        end else if (o_mem_wr_valid) begin
            if (wr_wait == 0) begin
                i_mem_wr_ready <= 1'b1;
                wr_wait        <= $urandom % 5;
            end else begin
                wr_wait <= wr_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (o_mem_rd_valid && i_mem_rd_ready) begin
            rd_cnt++;
            last_rd = o_mem_rd.addr;
        end
        if (o_mem_wr_valid && i_mem_wr_ready) begin
            wr_cnt++;
            last_wr = o_mem_wr.addr;
            mem_lines[o_mem_wr.addr] = o_mem_wr.line;
            checks++;
            assert (o_mem_wr.line == gold_line(o_mem_wr.addr)) else begin
                errors++;
                $display("FAILED %0t: write-back line at %h differs", $time, o_mem_wr.addr);
            end
        end
    end

    initial begin
        #(longint'(NREQ) * 200 * 10);
        $display("watchdog expired with requests still pending");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [31:0] a, b, c, a2, b2, c2, ad;
        int          r0, w0;
        void'($urandom(41975));
        a  = {19'd1, 7'd5, 6'd0};
        b  = {19'd2, 7'd5, 6'd0};
        c  = {19'd3, 7'd5, 6'd0};
        a2 = {19'd1, 7'd6, 6'd0};
        b2 = {19'd2, 7'd6, 6'd0};
        c2 = {19'd3, 7'd6, 6'd0};
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        // load miss then byte and half loads on the line
        r0 = rd_cnt;
        issue(a + 4, dcache_pkg::OP_LOAD, dcache_pkg::SIZE_WORD, 1'b0, '0);
        drain();
        check_count(rd_cnt, r0 + 1, "line read");
        check_count(int'(last_rd == a), 1, "read address match");
        for (int i = 0; i < 8; i++) begin
            issue(a + i, dcache_pkg::OP_LOAD, dcache_pkg::SIZE_BYTE, i[0], '0);
            issue(a + 2 * i, dcache_pkg::OP_LOAD, dcache_pkg::SIZE_HALF, i[1], '0);
        end
        drain();

        // store then load, merged data without traffic
        r0 = rd_cnt;
        w0 = wr_cnt;
        issue(a + 9, dcache_pkg::OP_STORE, dcache_pkg::SIZE_BYTE, 1'b0, 32'h0000_00c3);
        issue(a + 8, dcache_pkg::OP_LOAD, dcache_pkg::SIZE_WORD, 1'b0, '0);
        drain();
        check_count(rd_cnt - r0 + wr_cnt - w0, 0, "memory traffic on hit");

        // two dirty lines, a third evicts the older one
        issue(b + 16, dcache_pkg::OP_STORE, dcache_pkg::SIZE_WORD, 1'b0, 32'h8765_4321);
        drain();
        w0 = wr_cnt;
        issue(c, dcache_pkg::OP_LOAD, dcache_pkg::SIZE_WORD, 1'b0, '0);
        drain();
        check_count(wr_cnt, w0 + 1, "write-back");
        check_count(int'(last_wr == a), 1, "write-back address match");

        // LRU order A, B, A, C
        issue(a2, dcache_pkg::OP_LOAD, dcache_pkg::SIZE_WORD, 1'b0, '0);
        issue(b2, dcache_pkg::OP_LOAD, dcache_pkg::SIZE_WORD, 1'b0, '0);
        issue(a2, dcache_pkg::OP_LOAD, dcache_pkg::SIZE_WORD, 1'b0, '0);
        issue(c2, dcache_pkg::OP_LOAD, dcache_pkg::SIZE_WORD, 1'b0, '0);
        drain();
        r0 = rd_cnt;
        issue(a2, dcache_pkg::OP_LOAD, dcache_pkg::SIZE_WORD, 1'b0, '0);
        drain();
        check_count(rd_cnt, r0, "read for recent line");
        issue(b2, dcache_pkg::OP_LOAD, dcache_pkg::SIZE_WORD, 1'b0, '0);
        drain();
        check_count(rd_cnt, r0 + 1, "read for evicted line");

        // misaligned accesses fault and leave memory alone
        r0 = rd_cnt;
        w0 = wr_cnt;
        issue(a2 + 1, dcache_pkg::OP_LOAD, dcache_pkg::SIZE_HALF, 1'b1, '0);
        issue(a2 + 2, dcache_pkg::OP_STORE, dcache_pkg::SIZE_WORD, 1'b0, 32'hdead_beef);
        issue(a2, dcache_pkg::OP_LOAD, dcache_pkg::SIZE_WORD, 1'b0, '0);
        drain();
        check_count(rd_cnt - r0 + wr_cnt - w0, 0, "memory traffic on fault");

        // random traffic over 16 lines in 4 sets
        for (int n = 0; n < 2000; n++) begin
            ad = {19'($urandom % 4 + 1), 7'($urandom % 4 + 20), 6'($urandom % 64)};
            issue(ad, dcache_pkg::op_e'($urandom % 2), dcache_pkg::size_e'($urandom % 3),
                  1'($urandom % 2), $urandom);
        end
        drain();

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
src/dcache_pkg.sv
src/mem_bus_pkg.sv
src/dcache_ram.sv
src/dcache_set_state.sv
src/dcache_writeback.sv
src/dcache_align.sv
src/dcache_ctrl.sv
src/dcache.sv
tb/dcache_checker.sv
tb/dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb -f build.f -o dcache_tb

./obj_dir/dcache_tb > sim.log 2>&1 || true
cat sim.log

grep -q "All tests passed" sim.log
echo "simulation passed"
